//--- sim.f
+incdir+logic
logic/cpu_isa_pkg.sv
logic/cpu_core_pkg.sv
logic/alu.sv
logic/regfile.sv
logic/fetch_unit.sv
logic/exec_decoder.sv
logic/cpu_top.sv
test/tb_clock.sv
test/cpu_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the cpu testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f sim.f --top-module cpu_tb -o cpu_sim \
	> build.log 2>&1; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/cpu_sim > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "TESTBENCH PASSED" sim.log; then
	exit 0
fi
echo "pass line not found in sim.log"
exit 1

//--- test/cpu_tb.sv
`timescale 1ns/1ps

module cpu_tb
	import cpu_isa_pkg::*;
();

	localparam logic [15:0] RESET_VECTOR = 16'h4000;
	localparam logic [15:0] BYTE_ADDR = 16'h0100;
	localparam logic [15:0] WORD_ADDR = 16'h0102;
	localparam logic [15:0] SRC_ADDR = 16'h0200;
	localparam logic [15:0] JUMP_ADDR = 16'h4020;
	localparam int CYCLES_PER_ROW = 40;

	typedef struct {
		string name;
		opcode_t op;
		logic [15:0] a;
		logic [15:0] b;
		bit rnd;
		bit taken;
		logic [15:0] want;
	} row_t;

	logic clk;
	logic reset;
	logic [15:0] iread_addr;
	logic [23:0] iread_data = '0;
	logic [15:0] dread_addr;
	logic [15:0] dread_data = '0;
	logic [15:0] dwrite_addr;
	logic [15:0] dwrite_data;
	logic [1:0] dwrite_en;
	logic trap;

	logic [7:0] imem [0:65535];
	logic [7:0] dmem [0:65535];
	logic [15:0] load_addr;
	logic [31:0] rng = 32'h5f42;
	row_t rows [$];
	logic [15:0] st_addr [$];
	logic [15:0] st_data [$];
	logic [1:0] st_en [$];
	int cycles = 0;
	int limit = 0;

	tb_clock u_tb_clock (.clk);

	cpu_top u_cpu_top (.*);

	// both read ports answer one cycle after the address
	always @(posedge clk)
	begin
		iread_data <= {imem[iread_addr + 16'd2], imem[iread_addr + 16'd1], imem[iread_addr]};
		dread_data <= {dmem[dread_addr + 16'd1], dmem[dread_addr]};
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= limit)
		begin
			$display("timeout: the trap never came within %0d cycles", limit);
			$display("TESTBENCH FAILED");
			$fatal(1, "cycle limit reached");
		end
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// {carry or borrow, 8-bit result}
	function automatic logic [8:0] ref_alu8(input opcode_t op, input logic [7:0] a,
		input logic [7:0] b);
		case (op)
			OP_SUB_XL_IMM: return {a < b, a - b};
			OP_AND_XL_IMM: return {1'b0, a & b};
			OP_OR_XL_IMM:  return {1'b0, a | b};
			OP_XOR_XL_IMM: return {1'b0, a ^ b};
			OP_INC_XL:     return {1'b0, a} + 9'd1;
			default:       return {1'b0, a} + {1'b0, b};
		endcase
	endfunction

	task automatic compare_value(input string what, input logic [15:0] want,
		input logic [15:0] got);
		if (want !== got)
		begin
			$display("Mismatch in %s: expected %h, actual %h", what, want, got);
			$display("TESTBENCH FAILED");
			$fatal(1, "stopped at the first error");
		end
	endtask

	task automatic emit(input logic [7:0] v);
		imem[load_addr] = v;
		load_addr = load_addr + 16'd1;
	endtask

	task automatic emit_imm8(input opcode_t op, input logic [7:0] v);
		emit(op);
		emit(v);
	endtask

	task automatic emit_imm16(input opcode_t op, input logic [15:0] v);
		emit(op);
		emit(v[7:0]);
		emit(v[15:8]);
	endtask

	task automatic load_program(input opcode_t op, input logic [15:0] a, input logic [15:0] b);
		for (int i = 0; i < 256; i++)
			imem[RESET_VECTOR + i[15:0]] = 8'h00;
		load_addr = RESET_VECTOR;
		case (op)
			OP_ADDW_Y_IMM:
			begin
				emit_imm16(OP_LDW_Y_IMM, a);
				emit_imm16(OP_ADDW_Y_IMM, b);
				emit_imm16(OP_STW_DIR_Y, WORD_ADDR);
			end
			OP_ADD_XL_DIR:
			begin
				dmem[SRC_ADDR] = a[7:0];
				dmem[SRC_ADDR + 16'd1] = b[7:0];
				emit_imm16(OP_LD_XL_DIR, SRC_ADDR);
				emit_imm16(OP_ADD_XL_DIR, SRC_ADDR + 16'd1);
				emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
			end
			OP_JP_IMM:
			begin
				emit_imm8(OP_LD_XL_IMM, a[7:0]);
				emit_imm16(OP_JP_IMM, JUMP_ADDR);
				// only reached when the jump is lost
				emit(OP_TRAP);
				load_addr = JUMP_ADDR;
				emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
			end
			OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
			begin
				emit_imm8(OP_LD_XL_IMM, a[7:0]);
				emit_imm8(OP_ADD_XL_IMM, b[7:0]);
				// taken path lands on the second store 8 bytes past the jump
				emit_imm8(op, 8'd8);
				emit_imm8(OP_LD_XL_IMM, 8'd1);
				emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
				emit(OP_TRAP);
				emit_imm8(OP_LD_XL_IMM, 8'd2);
				emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
			end
			OP_INC_XL:
			begin
				emit_imm8(OP_LD_XL_IMM, a[7:0]);
				emit(OP_INC_XL);
				emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
			end
			default:
			begin
				emit_imm8(OP_LD_XL_IMM, a[7:0]);
				emit_imm8(op, b[7:0]);
				emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
			end
		endcase
		emit(OP_TRAP);
		// executes only once the next reset is already high
		emit_imm16(OP_ST_DIR_XL, BYTE_ADDR);
	endtask

	task automatic add_row(input string name, input opcode_t op, input logic [15:0] a,
		input logic [15:0] b, input bit rnd, input bit taken, input logic [15:0] want);
		row_t r;
		r.name = name;
		r.op = op;
		r.a = a;
		r.b = b;
		r.rnd = rnd;
		r.taken = taken;
		r.want = want;
		rows.push_back(r);
	endtask

	task automatic run_row(input row_t r);
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] want;
		logic [8:0] alu8;
		logic wide;
		a = r.a;
		b = r.b;
		want = r.want;
		wide = (r.op == OP_ADDW_Y_IMM);
		if (r.rnd)
		begin
			rng = next_random(rng);
			a = rng[15:0];
			rng = next_random(rng);
			b = rng[15:0];
			alu8 = ref_alu8(r.op, a[7:0], b[7:0]);
			want = wide ? a + b : {8'h00, alu8[7:0]};
		end

		@(posedge clk);
		reset <= 1'b1;
		load_program(r.op, a, b);
		repeat (16)
		begin
			@(negedge clk);
			compare_value({r.name, " reset iread_addr"}, RESET_VECTOR, iread_addr);
			compare_value({r.name, " reset dwrite_en"}, 16'h0000, {14'h0000, dwrite_en});
			compare_value({r.name, " reset trap"}, 16'h0000, 16'(trap));
			@(posedge clk);
		end
		reset <= 1'b0;
		st_addr.delete();
		st_data.delete();
		st_en.delete();

		// run to the trap and collect every store
		do
		begin
			@(negedge clk);
			if (dwrite_en != 2'b00)
			begin
				st_addr.push_back(dwrite_addr);
				st_data.push_back(dwrite_data);
				st_en.push_back(dwrite_en);
			end
		end
		while (!trap);

		compare_value({r.name, " store count"}, 16'd1, 16'(st_en.size()));
		compare_value({r.name, " store enable"}, wide ? 16'h0003 : 16'h0001,
			{14'h0000, st_en[0]});
		compare_value({r.name, " store address"}, wide ? WORD_ADDR : BYTE_ADDR, st_addr[0]);
		compare_value({r.name, " stored value"}, want, st_data[0]);
		if (r.op inside {OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC})
			compare_value({r.name, " branch taken"}, 16'(r.taken), 16'(st_data[0] == 16'h0002));
	endtask

	initial
	begin
		reset = 1'b1;
		for (int i = 0; i < 65536; i++)
		begin
			imem[i[15:0]] = 8'h00;
			dmem[i[15:0]] = i[7:0] ^ i[15:8] ^ 8'h5a;
		end

		// name, opcode, A, B, random operands, branch taken, stored value
		add_row("add_imm", OP_ADD_XL_IMM, 16'h003c, 16'h0025, 1'b0, 1'b0, 16'h0061);
		add_row("sub_borrow", OP_SUB_XL_IMM, 16'h0010, 16'h0020, 1'b0, 1'b0, 16'h00f0);
		add_row("and_imm", OP_AND_XL_IMM, 16'h00f5, 16'h003c, 1'b0, 1'b0, 16'h0034);
		add_row("or_imm", OP_OR_XL_IMM, 16'h00a0, 16'h0005, 1'b0, 1'b0, 16'h00a5);
		add_row("xor_imm", OP_XOR_XL_IMM, 16'h00ff, 16'h005a, 1'b0, 1'b0, 16'h00a5);
		add_row("inc_wrap", OP_INC_XL, 16'h00ff, 16'h0000, 1'b0, 1'b0, 16'h0000);
		add_row("addw_imm", OP_ADDW_Y_IMM, 16'h1234, 16'h0f0f, 1'b0, 1'b0, 16'h2143);
		add_row("addw_carry", OP_ADDW_Y_IMM, 16'hff00, 16'h0180, 1'b0, 1'b0, 16'h0080);
		add_row("add_dir", OP_ADD_XL_DIR, 16'h0044, 16'h0033, 1'b0, 1'b0, 16'h0077);
		add_row("jrz_taken", OP_JRZ, 16'h0080, 16'h0080, 1'b0, 1'b1, 16'h0002);
		add_row("jrz_not", OP_JRZ, 16'h0001, 16'h0001, 1'b0, 1'b0, 16'h0001);
		add_row("jrnz_taken", OP_JRNZ, 16'h0001, 16'h0001, 1'b0, 1'b1, 16'h0002);
		add_row("jrnz_not", OP_JRNZ, 16'h00ff, 16'h0001, 1'b0, 1'b0, 16'h0001);
		add_row("jrc_taken", OP_JRC, 16'h00ff, 16'h0002, 1'b0, 1'b1, 16'h0002);
		add_row("jrc_not", OP_JRC, 16'h0010, 16'h0020, 1'b0, 1'b0, 16'h0001);
		add_row("jrnc_taken", OP_JRNC, 16'h0010, 16'h0020, 1'b0, 1'b1, 16'h0002);
		add_row("jrnc_not", OP_JRNC, 16'h00c0, 16'h0040, 1'b0, 1'b0, 16'h0001);
		add_row("jp_abs", OP_JP_IMM, 16'h005e, 16'h0000, 1'b0, 1'b0, 16'h005e);
		add_row("add_rand", OP_ADD_XL_IMM, 16'h0000, 16'h0000, 1'b1, 1'b0, 16'h0000);
		add_row("sub_rand", OP_SUB_XL_IMM, 16'h0000, 16'h0000, 1'b1, 1'b0, 16'h0000);
		add_row("xor_rand", OP_XOR_XL_IMM, 16'h0000, 16'h0000, 1'b1, 1'b0, 16'h0000);
		add_row("addw_rand", OP_ADDW_Y_IMM, 16'h0000, 16'h0000, 1'b1, 1'b0, 16'h0000);
		add_row("dir_rand", OP_ADD_XL_DIR, 16'h0000, 16'h0000, 1'b1, 1'b0, 16'h0000);
		limit = rows.size() * CYCLES_PER_ROW;

		foreach (rows[i])
			run_row(rows[i]);

		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

module tb_clock
#(
	parameter int HALF_PERIOD = 10
)
(
	output logic clk
);

	initial
	begin
		clk = 1'b0;
		forever
			#HALF_PERIOD clk = ~clk;
	end

endmodule

//--- logic/cpu_top.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module cpu_top
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	output logic [`CPU_ADDR_W-1:0] iread_addr,
	input  logic [`CPU_INST_W-1:0] iread_data,
	output logic [`CPU_ADDR_W-1:0] dread_addr,
	input  logic [`CPU_DATA_W-1:0] dread_data,
	output logic [`CPU_ADDR_W-1:0] dwrite_addr,
	output logic [`CPU_DATA_W-1:0] dwrite_data,
	output logic [1:0]             dwrite_en,
	output logic                   trap
);

	inst_t inst;
	inst_t next_inst;
	flags_t next_flags;

	logic [`CPU_DATA_W-1:0] x;
	logic [`CPU_DATA_W-1:0] y;

	alu_op_t alu_op;
	logic [`CPU_DATA_W-1:0] alu_a;
	logic [`CPU_DATA_W-1:0] alu_b;
	logic [`CPU_DATA_W-1:0] alu_result;
	logic alu_c;
	logic alu_n;
	logic alu_z;

	reg_idx_t reg_idx;
	logic [1:0] reg_en;
	logic [`CPU_DATA_W-1:0] reg_data;

	fetch_unit u_fetch_unit (.*);

	exec_decoder u_exec_decoder (.*);

	// z is not an operand of any kept instruction
	regfile u_regfile (.clk, .reg_idx, .reg_en, .reg_data, .x, .y, .z());

	alu u_alu (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result),
		.c(alu_c), .n(alu_n), .z(alu_z));

endmodule

//--- logic/exec_decoder.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module exec_decoder
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  inst_t                  inst,
	input  inst_t                  next_inst,
	input  logic [`CPU_DATA_W-1:0] x,
	input  logic [`CPU_DATA_W-1:0] y,
	input  logic [`CPU_DATA_W-1:0] dread_data,
	input  logic [`CPU_DATA_W-1:0] alu_result,
	input  logic                   alu_c,
	input  logic                   alu_n,
	input  logic                   alu_z,
	output alu_op_t                alu_op,
	output logic [`CPU_DATA_W-1:0] alu_a,
	output logic [`CPU_DATA_W-1:0] alu_b,
	output reg_idx_t               reg_idx,
	output logic [1:0]             reg_en,
	output logic [`CPU_DATA_W-1:0] reg_data,
	output logic [`CPU_ADDR_W-1:0] dread_addr,
	output logic [`CPU_ADDR_W-1:0] dwrite_addr,
	output logic [`CPU_DATA_W-1:0] dwrite_data,
	output logic [1:0]             dwrite_en,
	output flags_t                 next_flags,
	output logic                   trap
);

	flags_t flags;
	logic [1:0] store_en;
	logic upd_c;
	logic upd_nz;
	logic [`CPU_DATA_W-1:0] imm8_ext;
	logic [`CPU_DATA_W-1:0] mem_byte;

	assign imm8_ext = {8'h00, inst.arg.b.imm8};
	assign mem_byte = {8'h00, dread_data[7:0]};

	// direct reads go out one cycle ahead of execute
	assign dread_addr = next_inst.arg.imm16;

	always_comb
	begin
		alu_op = PASS8;
		alu_a = x;
		alu_b = imm8_ext;
		reg_idx = X;
		reg_en = 2'b00;
		store_en = 2'b00;
		upd_c = 1'b0;
		upd_nz = 1'b0;
		dwrite_data = y;
		case (inst.opcode)
			OP_LD_XL_IMM:
			begin
				alu_a = imm8_ext;
				reg_en = 2'b01;
				upd_nz = 1'b1;
			end
			OP_LDW_Y_IMM:
			begin
				alu_op = PASSW;
				alu_a = inst.arg.imm16;
				reg_idx = Y;
				reg_en = 2'b11;
				upd_nz = 1'b1;
			end
			OP_LD_XL_DIR:
			begin
				alu_a = mem_byte;
				reg_en = 2'b01;
				upd_nz = 1'b1;
			end
			OP_ST_DIR_XL:
			begin
				dwrite_data = {8'h00, x[7:0]};
				store_en = 2'b01;
			end
			OP_STW_DIR_Y:
				store_en = 2'b11;
			OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM,
			OP_ADD_XL_DIR, OP_INC_XL:
			begin
				case (inst.opcode)
					OP_SUB_XL_IMM: alu_op = SUB;
					OP_AND_XL_IMM: alu_op = AND;
					OP_OR_XL_IMM:  alu_op = OR;
					OP_XOR_XL_IMM: alu_op = XOR;
					OP_INC_XL:     alu_op = INC;
					default:       alu_op = ADD;
				endcase
				if (inst.opcode == OP_ADD_XL_DIR)
					alu_b = mem_byte;
				reg_en = 2'b01;
				// logic ops come back from the alu with c cleared
				upd_c = 1'b1;
				upd_nz = 1'b1;
			end
			OP_ADDW_Y_IMM:
			begin
				alu_op = ADDW;
				alu_a = y;
				alu_b = inst.arg.imm16;
				reg_idx = Y;
				reg_en = 2'b11;
				upd_c = 1'b1;
				upd_nz = 1'b1;
			end
			default:
			begin
			end
		endcase
	end

	assign reg_data = alu_result;
	assign dwrite_addr = inst.arg.imm16;
	assign dwrite_en = reset ? 2'b00 : store_en;
	assign trap = !reset && inst.opcode == OP_TRAP;

	always_comb
	begin
		next_flags = flags;
		next_flags.reserved_hi = 4'h0;
		next_flags.reserved_lo = 1'b0;
		if (upd_c)
			next_flags.c = alu_c;
		if (upd_nz)
		begin
			next_flags.n = alu_n;
			next_flags.z = alu_z;
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			flags <= '0;
		else
			flags <= next_flags;
	end

	a_no_high_only: assert property (@(posedge clk) dwrite_en != 2'b10);
	a_quiet_in_reset: assert property (@(posedge clk) reset |-> dwrite_en == 2'b00);

endmodule

//--- logic/fetch_unit.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module fetch_unit
	import cpu_isa_pkg::*;
	import cpu_core_pkg::*;
(
	input  logic                   clk,
	input  logic                   reset,
	input  inst_t                  iread_data,
	input  flags_t                 next_flags,
	output logic [`CPU_ADDR_W-1:0] iread_addr,
	output inst_t                  inst,
	output inst_t                  next_inst
);

	// address of the word now in next_inst
	logic [`CPU_ADDR_W-1:0] pc;
	logic [`CPU_ADDR_W-1:0] next_pc;
	logic [`CPU_ADDR_W-1:0] inst_len;
	logic [`CPU_ADDR_W-1:0] disp;
	logic taken;

	assign next_inst = iread_data;
	assign disp = {{8{next_inst.arg.b.imm8[7]}}, next_inst.arg.b.imm8};

	always_comb
	begin
		case (next_inst.opcode)
			OP_LD_XL_IMM, OP_ADD_XL_IMM, OP_SUB_XL_IMM, OP_AND_XL_IMM, OP_OR_XL_IMM,
			OP_XOR_XL_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC:
				inst_len = `CPU_LEN_2;
			OP_LDW_Y_IMM, OP_LD_XL_DIR, OP_ST_DIR_XL, OP_STW_DIR_Y, OP_ADD_XL_DIR,
			OP_ADDW_Y_IMM, OP_JP_IMM:
				inst_len = `CPU_LEN_3;
			default:
				inst_len = `CPU_LEN_1;
		endcase

		// flags of the instruction ahead decide the branch
		case (next_inst.opcode)
			OP_JR:   taken = 1'b1;
			OP_JRZ:  taken = next_flags.z;
			OP_JRNZ: taken = !next_flags.z;
			OP_JRC:  taken = next_flags.c;
			OP_JRNC: taken = !next_flags.c;
			default: taken = 1'b0;
		endcase

		if (reset)
			next_pc = `CPU_RESET_PC;
		else if (next_inst.opcode == OP_JP_IMM)
			next_pc = next_inst.arg.imm16;
		else if (taken)
			next_pc = pc + disp;
		else
			next_pc = pc + inst_len;
	end

	assign iread_addr = next_pc;

	always_ff @(posedge clk)
	begin
		pc <= next_pc;
		if (reset)
			inst <= {16'h0000, OP_NOP};
		else
			inst <= next_inst;
	end

	a_known_opcode: assert property (@(posedge clk) disable iff (reset)
		$past(!reset) |-> inst.opcode inside {OP_NOP, OP_TRAP, OP_LD_XL_IMM, OP_LDW_Y_IMM,
			OP_LD_XL_DIR, OP_ST_DIR_XL, OP_STW_DIR_Y, OP_ADD_XL_IMM, OP_SUB_XL_IMM,
			OP_AND_XL_IMM, OP_OR_XL_IMM, OP_XOR_XL_IMM, OP_ADD_XL_DIR, OP_INC_XL,
			OP_ADDW_Y_IMM, OP_JP_IMM, OP_JR, OP_JRZ, OP_JRNZ, OP_JRC, OP_JRNC});

endmodule

//--- logic/regfile.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module regfile
	import cpu_core_pkg::*;
(
	input  logic                   clk,
	input  reg_idx_t               reg_idx,
	input  logic [1:0]             reg_en,
	input  logic [`CPU_DATA_W-1:0] reg_data,
	output logic [`CPU_DATA_W-1:0] x,
	output logic [`CPU_DATA_W-1:0] y,
	output logic [`CPU_DATA_W-1:0] z
);

	logic [`CPU_DATA_W-1:0] regs [3];
	logic [`CPU_DATA_W-1:0] next_regs [3];

	// merge the written bytes into the current values
	always_comb
	begin
		next_regs = regs;
		if (reg_en[0])
			next_regs[reg_idx][7:0] = reg_data[7:0];
		if (reg_en[1])
			next_regs[reg_idx][15:8] = reg_data[15:8];
	end

	always_ff @(posedge clk)
		regs <= next_regs;

	assign x = regs[X];
	assign y = regs[Y];
	assign z = regs[Z];

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps
`include "cpu_consts.svh"

module alu
	import cpu_core_pkg::*;
(
	input  alu_op_t                op,
	input  logic [`CPU_DATA_W-1:0] a,
	input  logic [`CPU_DATA_W-1:0] b,
	output logic [`CPU_DATA_W-1:0] result,
	output logic                   c,
	output logic                   n,
	output logic                   z
);

	logic [8:0] sum8;
	logic [16:0] sum16;
	logic wide;

	always_comb
	begin
		sum8 = '0;
		sum16 = '0;
		c = 1'b0;
		case (op)
			PASSW:
				result = a;
			ADD, SUB, INC:
			begin
				// carry out of bit 7, borrow for sub
				if (op == SUB)
					sum8 = {1'b0, a[7:0]} - {1'b0, b[7:0]};
				else if (op == INC)
					sum8 = {1'b0, a[7:0]} + 9'd1;
				else
					sum8 = {1'b0, a[7:0]} + {1'b0, b[7:0]};
				result = {8'h00, sum8[7:0]};
				c = sum8[8];
			end
			AND:
				result = {8'h00, a[7:0] & b[7:0]};
			OR:
				result = {8'h00, a[7:0] | b[7:0]};
			XOR:
				result = {8'h00, a[7:0] ^ b[7:0]};
			ADDW:
			begin
				sum16 = {1'b0, a} + {1'b0, b};
				result = sum16[15:0];
				c = sum16[16];
			end
			default:
				result = {8'h00, a[7:0]};
		endcase
	end

	assign wide = (op == PASSW) || (op == ADDW);
	assign n = wide ? result[15] : result[7];
	assign z = wide ? (result == '0) : (result[7:0] == 8'h00);

endmodule

//--- logic/cpu_core_pkg.sv
package cpu_core_pkg;

	typedef enum logic [3:0] {
		PASS8,
		PASSW,
		ADD,
		SUB,
		AND,
		OR,
		XOR,
		INC,
		ADDW
	} alu_op_t;

	// reserved bits stay zero
	typedef struct packed {
		logic [3:0] reserved_hi;
		logic z;
		logic n;
		logic c;
		logic reserved_lo;
	} flags_t;

	typedef enum logic [1:0] {
		X = 2'd0,
		Y = 2'd1,
		Z = 2'd2
	} reg_idx_t;

endpackage

//--- logic/cpu_isa_pkg.sv
package cpu_isa_pkg;

	typedef enum logic [7:0] {
		OP_NOP        = 8'h00,
		OP_TRAP       = 8'h01,
		OP_LD_XL_IMM  = 8'h10,
		OP_LDW_Y_IMM  = 8'h11,
		OP_LD_XL_DIR  = 8'h12,
		OP_ST_DIR_XL  = 8'h13,
		OP_STW_DIR_Y  = 8'h14,
		OP_ADD_XL_IMM = 8'h20,
		OP_SUB_XL_IMM = 8'h21,
		OP_AND_XL_IMM = 8'h22,
		OP_OR_XL_IMM  = 8'h23,
		OP_XOR_XL_IMM = 8'h24,
		OP_ADD_XL_DIR = 8'h25,
		OP_INC_XL     = 8'h26,
		OP_ADDW_Y_IMM = 8'h27,
		OP_JP_IMM     = 8'h30,
		OP_JR         = 8'h31,
		OP_JRZ        = 8'h32,
		OP_JRNZ       = 8'h33,
		OP_JRC        = 8'h34,
		OP_JRNC       = 8'h35
	} opcode_t;

	// imm8 overlays the low byte of imm16
	typedef union packed {
		logic [15:0] imm16;
		struct packed {
			logic [7:0] high;
			logic [7:0] imm8;
		} b;
	} operand_t;

	typedef struct packed {
		operand_t arg;
		opcode_t opcode;
	} inst_t;

endpackage

//--- logic/cpu_consts.svh
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// datapath widths
`define CPU_DATA_W 16
`define CPU_INST_W 24
`define CPU_ADDR_W 16

// first fetch address after reset
`define CPU_RESET_PC 16'h4000

// instruction lengths in bytes
// opcode only
`define CPU_LEN_1 1
// opcode plus imm8 or displacement
`define CPU_LEN_2 2
// opcode plus imm16 or direct address
`define CPU_LEN_3 3

`endif
